// File: design/umi_pkg.sv
// UMI package
// Field widths, FIFO depth default and the packed request packet
// shared by the dual-clock UMI FIFO and its wrapper

package umi_pkg;

   // ############################
   // Field widths
   // ############################

   localparam int umi_cw = 32;                            // Command word
   localparam int umi_aw = 64;                            // Each address field
   localparam int umi_dw = 256;                           // Data word
   localparam int umi_pw = umi_dw + 2 * umi_aw + umi_cw;  // Whole packet

   // Default number of FIFO entries, power of two
   localparam int umi_fifo_depth = 4;

   // ############################
   // Chaos pushback LFSR
   // ############################

   localparam int chaos_lfsr_w = 16;
   // Galois taps for x^16 + x^14 + x^13 + x^11 + 1, maximal length
   localparam logic [chaos_lfsr_w-1:0] chaos_lfsr_taps = 16'hb400;
   localparam logic [chaos_lfsr_w-1:0] chaos_lfsr_seed = 16'hace1;  // Any nonzero value

   // ############################
   // Packet
   // ############################

   // Same order as the FIFO word, data on top and cmd at the bottom
   typedef struct packed {
      logic [umi_dw-1:0] data;
      logic [umi_aw-1:0] srcaddr;
      logic [umi_aw-1:0] dstaddr;
      logic [umi_cw-1:0] cmd;
   } umi_packet_t;

endpackage

// File: design/umi_if.sv
// UMI request bus
// One packet per valid/ready beat, fields held while stalled

`timescale 1ns/1ps

interface umi_if;

   logic                      valid;    // Packet present
   logic [umi_pkg::umi_cw-1:0] cmd;     // Command word
   logic [umi_pkg::umi_aw-1:0] dstaddr; // Destination address
   logic [umi_pkg::umi_aw-1:0] srcaddr; // Source address
   logic [umi_pkg::umi_dw-1:0] data;    // Payload
   logic                      ready;    // Receiver can take it

   // Sender side
   modport source (
      output valid,
      output cmd,
      output dstaddr,
      output srcaddr,
      output data,
      input  ready
   );

   // Receiver side
   modport sink (
      input  valid,
      input  cmd,
      input  dstaddr,
      input  srcaddr,
      input  data,
      output ready
   );

endinterface

// File: design/la_asyncfifo.sv
// Dual-clock FIFO of UMI packets
// Gray pointers cross through two-flop synchronizers, full and empty are
// registered, and an LFSR can force extra full cycles for pushback stress

`timescale 1ns/1ps

module la_asyncfifo #(
   parameter int DEPTH = umi_pkg::umi_fifo_depth
) (
   // Write side
   input  logic                  wr_clk,
   input  logic                  wr_reset,
   input  logic                  wr_en,
   input  umi_pkg::umi_packet_t  wr_din,
   input  logic                  wr_chaosmode,
   output logic                  wr_full,
   // Read side
   input  logic                  rd_clk,
   input  logic                  rd_reset,
   input  logic                  rd_en,
   output umi_pkg::umi_packet_t  rd_dout,
   output logic                  rd_empty
);

   localparam int ptr_aw = $clog2(DEPTH);   // Address bits, pointers get one more

   // Storage, no reset
   logic [umi_pkg::umi_pw-1:0] mem [0:DEPTH-1];

   // Write domain state
   logic [ptr_aw:0] wr_bin, wr_bin_next, wr_gray;
   logic [ptr_aw:0] rd_gray_meta, rd_gray_sync;   // Read pointer, synchronized
   logic [ptr_aw:0] rd_bin_sync;
   logic [ptr_aw:0] wr_level;                    // Fill level as seen by writer
   logic            wr_full_q;
   logic            chaos_q;
   logic [umi_pkg::chaos_lfsr_w-1:0] lfsr;

   // Read domain state
   logic [ptr_aw:0] rd_bin, rd_bin_next, rd_gray;
   logic [ptr_aw:0] wr_gray_meta, wr_gray_sync;   // Write pointer, synchronized
   logic            rd_empty_q;

   function automatic logic [ptr_aw:0] bin2gray(input logic [ptr_aw:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [ptr_aw:0] gray2bin(input logic [ptr_aw:0] g);
      logic [ptr_aw:0] b;
      b[ptr_aw] = g[ptr_aw];
      for (int i = ptr_aw - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // ############################
   // Write domain
   // ############################

   assign wr_full     = wr_full_q | chaos_q;             // Both registered
   assign wr_bin_next = wr_bin + (wr_en & ~wr_full);     // Blocked while full
   assign rd_bin_sync = gray2bin(rd_gray_sync);
   assign wr_level    = wr_bin - rd_bin_sync;

   always_ff @(posedge wr_clk) begin
      if (wr_en && !wr_full) begin
         mem[wr_bin[ptr_aw-1:0]] <= wr_din;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_reset) begin
         wr_bin       <= '0;
         wr_gray      <= '0;
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
         wr_full_q    <= 1'b0;
      end else begin
         wr_bin       <= wr_bin_next;
         wr_gray      <= bin2gray(wr_bin_next);
         rd_gray_meta <= rd_gray;        // Two-flop synchronizer
         rd_gray_sync <= rd_gray_meta;
         // Full against a stale read pointer, so only ever pessimistic
         wr_full_q    <= (wr_bin_next - rd_bin_sync) == (ptr_aw + 1)'(DEPTH);
      end
   end

   // Chaos pushback, one random full cycle per set LFSR low bit
   always_ff @(posedge wr_clk) begin
      if (wr_reset) begin
         lfsr    <= umi_pkg::chaos_lfsr_seed;
         chaos_q <= 1'b0;
      end else begin
         lfsr    <= lfsr[0] ? ((lfsr >> 1) ^ umi_pkg::chaos_lfsr_taps) : (lfsr >> 1);
         chaos_q <= wr_chaosmode & lfsr[0];
      end
   end

   // ############################
   // Read domain
   // ############################

   assign rd_empty    = rd_empty_q;
   assign rd_bin_next = rd_bin + (rd_en & ~rd_empty);   // Blocked while empty
   assign rd_dout     = mem[rd_bin[ptr_aw-1:0]];        // Head entry, no read latency

   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         rd_bin       <= '0;
         rd_gray      <= '0;
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
         rd_empty_q   <= 1'b1;
      end else begin
         rd_bin       <= rd_bin_next;
         rd_gray      <= bin2gray(rd_bin_next);
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
         rd_empty_q   <= bin2gray(rd_bin_next) == wr_gray_sync;
      end
   end

   // ############################
   // Checks
   // ############################

   // A multi-bit jump would make the crossing unsafe
   a_rd_gray_one_bit: assert property (@(posedge wr_clk) disable iff (wr_reset)
      $countones(rd_gray_sync ^ $past(rd_gray_sync)) <= 1);

   a_wr_gray_one_bit: assert property (@(posedge rd_clk) disable iff (rd_reset)
      $countones(wr_gray_sync ^ $past(wr_gray_sync)) <= 1);

   // Writer never overruns the reader
   a_wr_level: assert property (@(posedge wr_clk) disable iff (wr_reset)
      wr_level <= (ptr_aw + 1)'(DEPTH));

endmodule

// File: design/umi_fifo.sv
// UMI FIFO wrapper
// Packs request fields into one FIFO word, runs both handshakes and
// muxes in a zero-latency bypass path

`timescale 1ns/1ps

module umi_fifo #(
   parameter int DEPTH = umi_pkg::umi_fifo_depth
) (
   input  logic umi_in_clk,
   input  logic umi_in_reset,
   input  logic umi_out_clk,
   input  logic umi_out_reset,
   input  logic bypass,        // Straight through, no storage
   input  logic chaosmode,     // Random pushback on the writer
   umi_if.sink   umi_in,
   umi_if.source umi_out,
   output logic fifo_full,
   output logic fifo_empty
);

   umi_pkg::umi_packet_t fifo_din;
   umi_pkg::umi_packet_t fifo_dout;
   logic                 fifo_write;
   logic                 fifo_read;

   // ############################
   // Handshake control
   // ############################

   assign fifo_write = umi_in.valid & ~fifo_full & ~bypass;   // In domain
   assign fifo_read  = ~fifo_empty & umi_out.ready;          // Out domain

   // Pack, same layout as the stored word
   assign fifo_din.cmd     = umi_in.cmd;
   assign fifo_din.dstaddr = umi_in.dstaddr;
   assign fifo_din.srcaddr = umi_in.srcaddr;
   assign fifo_din.data    = umi_in.data;

   la_asyncfifo #(
      .DEPTH (DEPTH)
   ) fifo (
      .wr_clk       (umi_in_clk),
      .wr_reset     (umi_in_reset),
      .wr_en        (fifo_write),
      .wr_din       (fifo_din),
      .wr_chaosmode (chaosmode),
      .wr_full      (fifo_full),
      .rd_clk       (umi_out_clk),
      .rd_reset     (umi_out_reset),
      .rd_en        (fifo_read),
      .rd_dout      (fifo_dout),
      .rd_empty     (fifo_empty)
   );

   // ############################
   // Bypass mux
   // ############################

   assign umi_out.cmd     = bypass ? umi_in.cmd     : fifo_dout.cmd;
   assign umi_out.dstaddr = bypass ? umi_in.dstaddr : fifo_dout.dstaddr;
   assign umi_out.srcaddr = bypass ? umi_in.srcaddr : fifo_dout.srcaddr;
   assign umi_out.data    = bypass ? umi_in.data    : fifo_dout.data;
   assign umi_out.valid   = bypass ? umi_in.valid   : ~fifo_empty;
   assign umi_in.ready    = bypass ? umi_out.ready  : ~fifo_full;   // Registered full

   // Stalled head stays put until the receiver takes it
   a_out_hold: assert property (@(posedge umi_out_clk) disable iff (umi_out_reset)
      (!bypass && umi_out.valid && !umi_out.ready) |=>
         (umi_out.valid && $stable(umi_out.cmd) && $stable(umi_out.dstaddr) &&
          $stable(umi_out.srcaddr) && $stable(umi_out.data)));

   // Switching modes with data inside would strand or reorder packets
   a_bypass_stable: assert property (@(posedge umi_out_clk) disable iff (umi_out_reset)
      !fifo_empty |-> $stable(bypass));

endmodule

// File: design/umi_fifo_top.sv
// UMI FIFO top level
// Plain request ports on both sides, mapped onto bus interfaces

`timescale 1ns/1ps

module umi_fifo_top #(
   parameter int DEPTH = umi_pkg::umi_fifo_depth
) (
   input  logic                       umi_in_clk,
   input  logic                       umi_in_reset,
   input  logic                       umi_out_clk,
   input  logic                       umi_out_reset,
   input  logic                       bypass,
   input  logic                       chaosmode,
   // Input request
   input  logic                       umi_in_valid,
   input  logic [umi_pkg::umi_cw-1:0] umi_in_cmd,
   input  logic [umi_pkg::umi_aw-1:0] umi_in_dstaddr,
   input  logic [umi_pkg::umi_aw-1:0] umi_in_srcaddr,
   input  logic [umi_pkg::umi_dw-1:0] umi_in_data,
   output logic                       umi_in_ready,
   // Output request
   output logic                       umi_out_valid,
   output logic [umi_pkg::umi_cw-1:0] umi_out_cmd,
   output logic [umi_pkg::umi_aw-1:0] umi_out_dstaddr,
   output logic [umi_pkg::umi_aw-1:0] umi_out_srcaddr,
   output logic [umi_pkg::umi_dw-1:0] umi_out_data,
   input  logic                       umi_out_ready,
   // Status
   output logic                       fifo_full,
   output logic                       fifo_empty
);

   umi_if in_bus ();    // Writer side, umi_in_clk
   umi_if out_bus ();   // Reader side, umi_out_clk

   // Input ports onto the bus
   assign in_bus.valid   = umi_in_valid;
   assign in_bus.cmd     = umi_in_cmd;
   assign in_bus.dstaddr = umi_in_dstaddr;
   assign in_bus.srcaddr = umi_in_srcaddr;
   assign in_bus.data    = umi_in_data;
   assign umi_in_ready   = in_bus.ready;

   // Bus back out to ports
   assign umi_out_valid   = out_bus.valid;
   assign umi_out_cmd     = out_bus.cmd;
   assign umi_out_dstaddr = out_bus.dstaddr;
   assign umi_out_srcaddr = out_bus.srcaddr;
   assign umi_out_data    = out_bus.data;
   assign out_bus.ready   = umi_out_ready;

   umi_fifo #(
      .DEPTH (DEPTH)
   ) u_fifo (
      .umi_in_clk    (umi_in_clk),
      .umi_in_reset  (umi_in_reset),
      .umi_out_clk   (umi_out_clk),
      .umi_out_reset (umi_out_reset),
      .bypass        (bypass),
      .chaosmode     (chaosmode),
      .umi_in        (in_bus.sink),
      .umi_out       (out_bus.source),
      .fifo_full     (fifo_full),
      .fifo_empty    (fifo_empty)
   );

endmodule

// File: test/tb_umi_checks.svh
// UMI FIFO testbench checks
// Typed compares, error counters and bounded waits on the DUT status

`ifndef TB_UMI_CHECKS_SVH
`define TB_UMI_CHECKS_SVH

int mismatch_count = 0;   // Wrong values
int timeout_count  = 0;   // Waits that ran out
int stray_count    = 0;   // Packets with no match in the scoreboard

task automatic check_packet(input string name, input umi_pkg::umi_packet_t exp,
                            input umi_pkg::umi_packet_t act);
   if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      mismatch_count++;
   end
endtask

task automatic check_count(input string name, input int exp, input int act);
   if (act != exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      mismatch_count++;
   end
endtask

// Sampled on in-clock edges, returns at the edge where ready matched
task automatic wait_in_ready(input string name, input logic value, input int limit,
                             input bit report, output bit ok);
   int cycles;
   ok     = 1'b0;
   cycles = 0;
   while (!ok && cycles < limit) begin
      @(posedge umi_in_clk);
      ok = (umi_in_ready === value);
      cycles++;
   end
   if (!ok && report) begin
      $display("%s: umi_in_ready did not reach %b within %0d cycles", name, value, limit);
      timeout_count++;
   end
endtask

task automatic wait_out_empty(input string name, input int limit);
   int cycles;
   cycles = 0;
   do begin
      @(posedge umi_out_clk);
      cycles++;
   end while (fifo_empty !== 1'b1 && cycles < limit);
   if (fifo_empty !== 1'b1) begin
      $display("%s: FIFO did not go empty within %0d cycles", name, limit);
      timeout_count++;
   end
endtask

`endif

// File: test/tb_umi_fifo.sv
// UMI FIFO testbench
// Directed tests of the dual-clock packet FIFO against a queue scoreboard

`timescale 1ns/1ps

module tb_umi_fifo;

   localparam int depth       = umi_pkg::umi_fifo_depth;
   localparam int wait_limit  = 64;   // Cycles per handshake
   localparam int stall_limit = 12;   // Ready low this long means the writer is blocked

   // DUT ports named as on umi_fifo_top
   logic                       umi_in_clk;
   logic                       umi_in_reset;
   logic                       umi_out_clk;
   logic                       umi_out_reset;
   logic                       bypass;
   logic                       chaosmode;
   logic                       umi_in_valid;
   logic [umi_pkg::umi_cw-1:0] umi_in_cmd;
   logic [umi_pkg::umi_aw-1:0] umi_in_dstaddr;
   logic [umi_pkg::umi_aw-1:0] umi_in_srcaddr;
   logic [umi_pkg::umi_dw-1:0] umi_in_data;
   logic                       umi_in_ready;
   logic                       umi_out_valid;
   logic [umi_pkg::umi_cw-1:0] umi_out_cmd;
   logic [umi_pkg::umi_aw-1:0] umi_out_dstaddr;
   logic [umi_pkg::umi_aw-1:0] umi_out_srcaddr;
   logic [umi_pkg::umi_dw-1:0] umi_out_data;
   logic                       umi_out_ready;
   logic                       fifo_full;
   logic                       fifo_empty;

   integer               seed;             // $random state
   umi_pkg::umi_packet_t expected_q [$];   // Scoreboard in send order

   umi_fifo_top #(
      .DEPTH (depth)
   ) dut (.*);

   `include "tb_umi_checks.svh"

   // ############################
   // Clocks and stimulus helpers
   // ############################

   always #2 umi_in_clk = ~umi_in_clk;     // Rises at 2, 6, 10

   always begin
      if ($time == 0) #1;                  // Offset start
      #2 umi_out_clk = ~umi_out_clk;       // Rises at 3, 7, 11
   end

   function automatic umi_pkg::umi_packet_t random_packet();
      umi_pkg::umi_packet_t p;
      p.cmd     = $random(seed);
      p.dstaddr = {$random(seed), $random(seed)};
      p.srcaddr = {$random(seed), $random(seed)};
      for (int i = 0; i < umi_pkg::umi_dw / 32; i++) begin
         p.data[i*32 +: 32] = $random(seed);
      end
      return p;
   endfunction

   // Out fields gathered back into a packet
   function automatic umi_pkg::umi_packet_t out_packet();
      umi_pkg::umi_packet_t p;
      p.cmd     = umi_out_cmd;
      p.dstaddr = umi_out_dstaddr;
      p.srcaddr = umi_out_srcaddr;
      p.data    = umi_out_data;
      return p;
   endfunction

   task automatic drive_in(input logic valid, input umi_pkg::umi_packet_t p);
      umi_in_valid   = valid;
      umi_in_cmd     = p.cmd;
      umi_in_dstaddr = p.dstaddr;
      umi_in_srcaddr = p.srcaddr;
      umi_in_data    = p.data;
   endtask

   // Writer holds each packet until the edge that accepts it
   task automatic send_packets(input string name, input int count);
      umi_pkg::umi_packet_t pkt;
      bit ok;
      ok = 1'b1;
      @(posedge umi_in_clk);
      for (int i = 0; i < count && ok; i++) begin
         pkt = random_packet();
         #1;
         drive_in(1'b1, pkt);
         wait_in_ready(name, 1'b1, wait_limit, 1'b1, ok);
         if (ok) expected_q.push_back(pkt);   // Accepted on this edge
      end
      #1;
      drive_in(1'b0, '0);
   endtask

   // Reader compares each beat against the oldest sent packet
   task automatic receive_packets(input string name, input int count, input bit random_ready);
      int received;
      int idle;
      received = 0;
      idle     = 0;
      @(posedge umi_out_clk);
      #1;
      umi_out_ready = random_ready ? 1'($random(seed)) : 1'b1;
      while (received < count && idle < wait_limit) begin
         @(posedge umi_out_clk);
         if (umi_out_valid === 1'b1 && umi_out_ready === 1'b1) begin
            if (expected_q.size() == 0) begin
               $display("%s: packet arrived that was never sent", name);
               stray_count++;
            end else begin
               check_packet(name, expected_q.pop_front(), out_packet());
            end
            received++;
            idle = 0;
         end else begin
            idle++;
         end
         #1;
         umi_out_ready = random_ready ? 1'($random(seed)) : 1'b1;
      end
      if (received < count) begin
         $display("%s: only %0d of %0d packets arrived in time", name, received, count);
         timeout_count++;
      end
      umi_out_ready = 1'b0;
   endtask

   task automatic run_stream(input string name, input int count, input bit random_ready);
      fork
         send_packets(name, count);
         receive_packets(name, count, random_ready);
      join
      wait_out_empty(name, wait_limit);   // An extra or repeated packet stays stuck here
      expected_q.delete();
   endtask

   // ############################
   // Directed tests
   // ############################

   task automatic test_reset();
      @(posedge umi_out_clk);
      check_bit("reset umi_out_valid", 1'b0, umi_out_valid);
      check_bit("reset fifo_empty", 1'b1, fifo_empty);
      @(posedge umi_in_clk);
      check_bit("reset fifo_full", 1'b0, fifo_full);
      check_bit("reset umi_in_ready", 1'b1, umi_in_ready);
   endtask

   task automatic test_stream();
      run_stream("stream", 20, 1'b0);
   endtask

   task automatic test_fill();
      umi_pkg::umi_packet_t pkt;
      bit ok;
      int accepted;
      accepted = 0;
      wait_in_ready("fill settle", 1'b1, wait_limit, 1'b1, ok);
      while (ok && accepted <= depth) begin   // One offer past depth has to stall
         pkt = random_packet();
         #1;
         drive_in(1'b1, pkt);
         wait_in_ready("fill", 1'b1, stall_limit, 1'b0, ok);
         if (ok) begin
            expected_q.push_back(pkt);
            accepted++;
         end
      end
      #1;
      drive_in(1'b0, '0);
      check_count("fill accepted", depth, accepted);
      @(posedge umi_in_clk);
      check_bit("fill fifo_full", 1'b1, fifo_full);
      check_bit("fill umi_in_ready", 1'b0, umi_in_ready);
      receive_packets("fill", depth, 1'b0);   // Drain in order
      wait_out_empty("fill", wait_limit);
      check_bit("fill umi_out_valid", 1'b0, umi_out_valid);
      expected_q.delete();
   endtask

   task automatic test_backpressure();
      run_stream("backpressure", 30, 1'b1);
   endtask

   // Combinational path checked on the in clock for both clocks
   task automatic test_bypass();
      umi_pkg::umi_packet_t pkt;
      logic ready;
      wait_out_empty("bypass", wait_limit);   // Mode change only while empty
      @(posedge umi_in_clk);
      for (int i = 0; i < 8; i++) begin
         pkt   = random_packet();
         ready = i[0];                        // Both ready levels
         #1;
         bypass        = 1'b1;
         umi_out_ready = ready;
         drive_in(1'b1, pkt);
         @(posedge umi_in_clk);
         check_packet("bypass packet", pkt, out_packet());
         check_bit("bypass umi_out_valid", 1'b1, umi_out_valid);
         check_bit("bypass umi_in_ready", ready, umi_in_ready);
         check_bit("bypass fifo_empty", 1'b1, fifo_empty);   // Nothing stored
      end
      #1;
      bypass        = 1'b0;
      umi_out_ready = 1'b0;
      drive_in(1'b0, '0);
   endtask

   task automatic test_chaos();
      bit ok;
      wait_in_ready("chaos settle", 1'b1, wait_limit, 1'b1, ok);
      #1;
      chaosmode = 1'b1;
      // No writes yet, so a low ready here is pushback alone
      wait_in_ready("chaos pushback", 1'b0, wait_limit, 1'b1, ok);
      run_stream("chaos", 30, 1'b0);
      chaosmode = 1'b0;
   endtask

   // ############################
   // Main sequence
   // ############################

   initial begin
      seed          = 65;
      umi_in_clk    = 1'b0;
      umi_out_clk   = 1'b0;
      umi_in_reset  = 1'b1;
      umi_out_reset = 1'b1;
      bypass        = 1'b0;
      chaosmode     = 1'b0;
      umi_out_ready = 1'b0;
      drive_in(1'b0, '0);
      fork   // Each reset released on its own clock
         begin
            repeat (2) @(posedge umi_in_clk);
            #1 umi_in_reset = 1'b0;
         end
         begin
            repeat (2) @(posedge umi_out_clk);
            #1 umi_out_reset = 1'b0;
         end
      join
      test_reset();
      test_stream();
      test_fill();
      test_backpressure();
      test_bypass();
      test_chaos();
      $display("errors: %0d mismatches, %0d timeouts, %0d stray packets",
               mismatch_count, timeout_count, stray_count);
      if (mismatch_count + timeout_count + stray_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+test
design/umi_pkg.sv
design/umi_if.sv
design/la_asyncfifo.sv
design/umi_fifo.sv
design/umi_fifo_top.sv
test/tb_umi_fifo.sv

// File: Makefile
# Verilator build and run of the UMI FIFO testbench
# Variables can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_umi_fifo
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
